//--- rtl/pkt_match_settings.svh
// Packet matcher build constants for word layout, match fields and FIFO sizing
`ifndef PKT_MATCH_SETTINGS_SVH
`define PKT_MATCH_SETTINGS_SVH

// Bytes carried by one packet word
`define PM_WORD_BYTES 8

// Type field is 4 bytes and must sit inside a single word
`define PM_TYPE_BYTES 4

// Highest byte offset where the whole type field still fits in a word
`define PM_TYPE_MAX_OFF 4

// Symbol table size per packet
`define PM_SYM_ENTRIES 4

// Word offset counter width, saturates at the top value
`define PM_WORD_OFF_W 4

// Length field holds the index of the last valid byte
`define PM_LEN_W 3

// Buffer id width
`define PM_BUF_W 4

// FIFO entries, also the credit count after reset
`define PM_FIFO_DEPTH 8

`endif

//--- rtl/pkt_match_pkg.sv
// Packet matcher types for stream words, symbol entries and the packet FSM
`include "pkt_match_settings.svh"

package pkt_match_pkg;

  // Field types
  typedef logic [`PM_LEN_W-1:0]              len_t;
  typedef logic [`PM_WORD_OFF_W-1:0]         word_off_t;
  typedef logic [$clog2(`PM_WORD_BYTES)-1:0] byte_off_t;
  typedef logic [`PM_BUF_W-1:0]              buf_id_t;
  typedef logic [`PM_WORD_BYTES*8-1:0]       data_t;
  typedef logic [`PM_TYPE_BYTES*8-1:0]       type_val_t;

  // One word of a packet, byte 0 in the low bits of data
  typedef struct packed {
    logic  sop;
    logic  eop;
    len_t  length;
    data_t data;
  } pkt_word_t;

  // Word plus the verdict, verdict only nonzero on the eop word
  typedef struct packed {
    pkt_word_t word;
    logic      hit;
    buf_id_t   buffer;
  } tagged_word_t;

  // One symbol table entry
  typedef struct packed {
    logic      valid;
    word_off_t word_off;
    data_t     value;
    buf_id_t   buffer;
  } sym_entry_t;

  // Packet tracking FSM
  typedef enum logic {
    IDLE      = 1'b0,
    IN_PACKET = 1'b1
  } match_state_t;

endpackage

//--- rtl/pkt_stream_ifs.sv
// Internal links of the packet matcher, credit push path and FIFO read path

// Push channel from the matcher into the FIFO
// Source pushes only while holding a credit, one credit back per pop
interface credit_if
  import pkt_match_pkg::*;
();

  logic         push;
  tagged_word_t word;
  logic         credit_ret;

  // Producer side
  modport src (
    output push,
    output word,
    input  credit_ret
  );

  // FIFO side
  modport dst (
    input  push,
    input  word,
    output credit_ret
  );

endinterface

// Read channel from the FIFO into the egress stage
// Head is valid in the same cycle as not_empty
interface fifo_rd_if
  import pkt_match_pkg::*;
();

  logic         not_empty;
  tagged_word_t head;
  logic         pop;

  // FIFO side
  modport src (
    output not_empty,
    output head,
    input  pop
  );

  // Consumer side
  modport dst (
    input  not_empty,
    input  head,
    output pop
  );

endinterface

//--- rtl/word_matcher.sv
// Packet word matcher with type and symbol search, packet FSM and credit counter
`include "pkt_match_settings.svh"

module word_matcher
  import pkt_match_pkg::*;
(
  input  logic                             clk_net,
  input  logic                             rst,
  input  logic                             in_vld,
  output logic                             in_rdy,
  input  pkt_word_t                        in_word,
  input  word_off_t                        type_word,
  input  byte_off_t                        type_off,
  input  type_val_t                        type_value,
  input  sym_entry_t [`PM_SYM_ENTRIES-1:0] sym,
  credit_if.src                            cq
);

  localparam int        CRED_W  = $clog2(`PM_FIFO_DEPTH + 1);
  localparam word_off_t OFF_MAX = '1;

  // Input register
  logic                             accept;
  logic                             in_vld_r;
  pkt_word_t                        in_r;
  // Settings latched with the start word
  word_off_t                        type_word_r;
  byte_off_t                        type_off_r;
  type_val_t                        type_value_r;
  sym_entry_t [`PM_SYM_ENTRIES-1:0] sym_r;
  // Packet tracking
  match_state_t                     state_r;
  match_state_t                     state_nxt;
  word_off_t                        word_off_r;
  word_off_t                        cur_off;
  logic                             pkt_word;
  logic                             drop;
  logic                             type_seen_r;
  logic                             sym_seen_r;
  buf_id_t                          buf_r;
  // Match results for the registered word
  logic [`PM_WORD_BYTES-1:0]        valid_mask;
  logic [`PM_WORD_BYTES-1:0]        type_pos;
  logic                             type_hit;
  logic                             sym_hit;
  buf_id_t                          sym_buf;
  logic                             type_acc;
  logic                             sym_acc;
  buf_id_t                          buf_acc;
  logic                             verdict;
  logic [CRED_W-1:0]                credits_r;

  // Ready while any FIFO slot is still owed to us
  assign in_rdy = (credits_r != '0);
  assign accept = in_vld & in_rdy;

  always_ff @(posedge clk_net) begin
    if (rst) begin
      in_vld_r <= 1'b0;
    end else begin
      in_vld_r <= accept;
    end
  end

  // Word and settings capture, settings only on a start word
  always_ff @(posedge clk_net) begin
    if (accept) begin
      in_r <= in_word;
    end
    if (accept && in_word.sop) begin
      type_word_r  <= type_word;
      type_off_r   <= type_off;
      type_value_r <= type_value;
      sym_r        <= sym;
    end
  end

  // A start word always opens a packet, even in the middle of one
  always_comb begin
    pkt_word  = 1'b0;
    state_nxt = state_r;
    if (in_vld_r && (in_r.sop || state_r == IN_PACKET)) begin
      pkt_word  = 1'b1;
      state_nxt = in_r.eop ? IDLE : IN_PACKET;
    end
  end

  // Stray word outside a packet
  assign drop    = in_vld_r & ~pkt_word;
  // Start word sits at offset zero
  assign cur_off = in_r.sop ? '0 : word_off_r;

  // Type search at every legal byte offset, compare only valid bytes
  always_comb begin
    for (int i = 0; i < `PM_WORD_BYTES; i++) begin
      valid_mask[i] = (i <= int'(in_r.length));
    end
    type_pos = '0;
    for (int i = 0; i <= `PM_TYPE_MAX_OFF; i++) begin
      type_pos[i] = 1'b1;
      for (int j = 0; j < `PM_TYPE_BYTES; j++) begin
        if (!valid_mask[i+j] || type_value_r[8*j +: 8] != in_r.data[8*(i+j) +: 8]) begin
          type_pos[i] = 1'b0;
        end
      end
    end
    type_hit = (cur_off == type_word_r) && (int'(type_off_r) <= `PM_TYPE_MAX_OFF) &&
               type_pos[type_off_r];
  end

  // Symbol compare on full words only, highest matching entry wins
  always_comb begin
    sym_hit = 1'b0;
    sym_buf = '0;
    for (int k = 0; k < `PM_SYM_ENTRIES; k++) begin
      if (sym_r[k].valid && sym_r[k].word_off == cur_off &&
          in_r.length == len_t'(`PM_WORD_BYTES - 1) && in_r.data == sym_r[k].value) begin
        sym_hit = 1'b1;
        sym_buf = sym_r[k].buffer;
      end
    end
  end

  // Running packet state including this word, cleared by a start word
  assign type_acc = (~in_r.sop & type_seen_r) | type_hit;
  assign sym_acc  = (~in_r.sop & sym_seen_r) | sym_hit;
  assign buf_acc  = sym_hit ? sym_buf : buf_r;
  assign verdict  = in_r.eop & type_acc & sym_acc;

  // Push every packet word the cycle after capture
  assign cq.push        = pkt_word;
  assign cq.word.word   = in_r;
  assign cq.word.hit    = verdict;
  assign cq.word.buffer = verdict ? buf_acc : '0;

  always_ff @(posedge clk_net) begin
    if (rst) begin
      state_r     <= IDLE;
      word_off_r  <= '0;
      type_seen_r <= 1'b0;
      sym_seen_r  <= 1'b0;
    end else if (pkt_word) begin
      state_r     <= state_nxt;
      // Offset holds at the top value once reached
      word_off_r  <= (cur_off == OFF_MAX) ? OFF_MAX : cur_off + 1'b1;
      type_seen_r <= type_acc;
      sym_seen_r  <= sym_acc;
    end
  end

  // Latest matching word sets the buffer id
  always_ff @(posedge clk_net) begin
    if (pkt_word) begin
      buf_r <= buf_acc;
    end
  end

  // Spend on accept, regain on FIFO pop or on a dropped word
  always_ff @(posedge clk_net) begin
    if (rst) begin
      credits_r <= CRED_W'(`PM_FIFO_DEPTH);
    end else begin
      credits_r <= credits_r - CRED_W'(accept) + CRED_W'(cq.credit_ret) + CRED_W'(drop);
    end
  end

endmodule

//--- rtl/tag_fifo.sv
// Synchronous FIFO of tagged words that hands back one credit per pop
`include "pkt_match_settings.svh"

module tag_fifo
  import pkt_match_pkg::*;
(
  input  logic   clk_net,
  input  logic   rst,
  credit_if.dst  cq,
  fifo_rd_if.src rd
);

  localparam int DEPTH = `PM_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage and pointers
  tagged_word_t     mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [CNT_W-1:0] count_r;

  // Circular increment, any depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Credits keep pushes away from a full FIFO
  always_ff @(posedge clk_net) begin
    if (cq.push) begin
      mem[wr_ptr_r] <= cq.word;
    end
  end

  always_ff @(posedge clk_net) begin
    if (rst) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (cq.push) begin
        wr_ptr_r <= ptr_inc(wr_ptr_r);
      end
      if (rd.pop) begin
        rd_ptr_r <= ptr_inc(rd_ptr_r);
      end
      count_r <= count_r + CNT_W'(cq.push) - CNT_W'(rd.pop);
    end
  end

  // Head visible the cycle after the push lands
  assign rd.not_empty = (count_r != '0);
  assign rd.head      = mem[rd_ptr_r];

  // Freed slot goes straight back to the matcher
  assign cq.credit_ret = rd.pop;

endmodule

//--- rtl/egress_stage.sv
// Output register stage with valid/ready back-pressure fed from the FIFO

module egress_stage
  import pkt_match_pkg::*;
(
  input  logic         clk_net,
  input  logic         rst,
  input  logic         out_rdy,
  output logic         out_vld,
  output tagged_word_t out_word,
  fifo_rd_if.dst       rd
);

  // Register free next edge when empty or being taken now
  logic load;

  assign load   = rd.not_empty & (~out_vld | out_rdy);
  assign rd.pop = load;

  // Valid bit
  always_ff @(posedge clk_net) begin
    if (rst) begin
      out_vld <= 1'b0;
    end else if (load) begin
      out_vld <= 1'b1;
    end else if (out_rdy) begin
      out_vld <= 1'b0;
    end
  end

  // Payload held while stalled, only a pop replaces it
  always_ff @(posedge clk_net) begin
    if (load) begin
      out_word <= rd.head;
    end
  end

endmodule

//--- rtl/pkt_match_top.sv
// Packet matcher top level joining matcher, tag FIFO and egress register
`include "pkt_match_settings.svh"

module pkt_match_top
  import pkt_match_pkg::*;
(
  input  logic                                        clk_net,
  input  logic                                        rst,
  // Ingress stream
  input  logic                                        in_vld,
  output logic                                        in_rdy,
  input  logic                                        in_sop,
  input  logic                                        in_eop,
  input  len_t                                        in_length,
  input  data_t                                       in_data,
  // Type field settings
  input  word_off_t                                   type_word,
  input  byte_off_t                                   type_off,
  input  type_val_t                                   type_value,
  // Symbol table, entry k in slice k
  input  logic [`PM_SYM_ENTRIES-1:0]                  sym_valid,
  input  logic [`PM_SYM_ENTRIES*`PM_WORD_OFF_W-1:0]   sym_word,
  input  logic [`PM_SYM_ENTRIES*`PM_WORD_BYTES*8-1:0] sym_value,
  input  logic [`PM_SYM_ENTRIES*`PM_BUF_W-1:0]        sym_buffer,
  // Egress stream
  input  logic                                        out_rdy,
  output logic                                        out_vld,
  output logic                                        out_sop,
  output logic                                        out_eop,
  output len_t                                        out_length,
  output data_t                                       out_data,
  output logic                                        out_hit,
  output buf_id_t                                     out_buffer
);

  pkt_word_t                        in_word;
  sym_entry_t [`PM_SYM_ENTRIES-1:0] sym_cfg;
  tagged_word_t                     out_word;

  credit_if  cq_if ();
  fifo_rd_if rd_if ();

  // Pack the flat ingress fields
  assign in_word.sop    = in_sop;
  assign in_word.eop    = in_eop;
  assign in_word.length = in_length;
  assign in_word.data   = in_data;

  // Slice the flat symbol buses into entries
  for (genvar k = 0; k < `PM_SYM_ENTRIES; k++) begin : g_sym
    assign sym_cfg[k].valid    = sym_valid[k];
    assign sym_cfg[k].word_off = sym_word[k*`PM_WORD_OFF_W +: `PM_WORD_OFF_W];
    assign sym_cfg[k].value    = sym_value[k*`PM_WORD_BYTES*8 +: `PM_WORD_BYTES*8];
    assign sym_cfg[k].buffer   = sym_buffer[k*`PM_BUF_W +: `PM_BUF_W];
  end

  word_matcher u_matcher (
    .clk_net    (clk_net),
    .rst        (rst),
    .in_vld     (in_vld),
    .in_rdy     (in_rdy),
    .in_word    (in_word),
    .type_word  (type_word),
    .type_off   (type_off),
    .type_value (type_value),
    .sym        (sym_cfg),
    .cq         (cq_if.src)
  );

  tag_fifo u_fifo (
    .clk_net (clk_net),
    .rst     (rst),
    .cq      (cq_if.dst),
    .rd      (rd_if.src)
  );

  egress_stage u_egress (
    .clk_net  (clk_net),
    .rst      (rst),
    .out_rdy  (out_rdy),
    .out_vld  (out_vld),
    .out_word (out_word),
    .rd       (rd_if.dst)
  );

  // Flatten the egress register
  assign out_sop    = out_word.word.sop;
  assign out_eop    = out_word.word.eop;
  assign out_length = out_word.word.length;
  assign out_data   = out_word.word.data;
  assign out_hit    = out_word.hit;
  assign out_buffer = out_word.buffer;

endmodule

//--- verification/pkt_match_tb.sv
// Packet matcher testbench with a word table, random stalls and a scoreboard
`include "pkt_match_settings.svh"

module pkt_match_tb
  import pkt_match_pkg::*;
();

  localparam logic [31:0] TV = 32'hA1B2_C3D4;
  localparam logic [63:0] SA = 64'h5A5A_1234_9876_0F0F;
  localparam logic [63:0] SB = 64'h3C3C_4321_6789_F0F0;
  localparam logic [63:0] SC = 64'h7E7E_ABCD_0000_1111;
  localparam int TMO = 400;

  // One table row is one input word with its settings and expected verdict
  typedef struct packed {
    logic        sop;
    logic        eop;
    logic [2:0]  len;
    logic [63:0] data;
    logic [3:0]  tw;
    logic [2:0]  to;
    logic        hit;
    logic [3:0]  bf;
  } row_t;

  logic clk_net, rst, in_vld, in_rdy, in_sop, in_eop, out_rdy, out_vld;
  logic out_sop, out_eop, out_hit;
  logic [2:0] in_length, type_off, out_length;
  logic [63:0] in_data, out_data;
  logic [3:0] type_word, out_buffer;
  logic [31:0] type_value;
  logic [3:0] sym_valid;
  logic [15:0] sym_word, sym_buffer;
  logic [255:0] sym_value;

  row_t rows[$];
  tagged_word_t expq[$];
  tagged_word_t held;
  logic stalled_prev;
  logic in_pkt;
  logic hold_rdy;
  int errors, checks, accepted, rows_done, acc_before, guard;

  pkt_match_top uut (.*);

  initial begin
    clk_net = 1'b0;
    forever #10 clk_net = ~clk_net;
  end

  // Random out_rdy stalls unless held low
  always @(posedge clk_net) begin
    out_rdy <= hold_rdy ? 1'b0 : ($urandom % 4 != 0);
  end

  task automatic abort(input string what);
    $display("ERROR: timeout while %s", what);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Simulation FAILED");
    $finish;
  endtask

  task automatic add_row(input logic sop, input logic eop, input logic [2:0] len,
                         input logic [63:0] data, input logic [3:0] tw,
                         input logic [2:0] to, input logic hit, input logic [3:0] bf);
    rows.push_back({sop, eop, len, data, tw, to, hit, bf});
  endtask

  // Drive rows lo..hi-1, each held until accepted
  task automatic send_rows(input int lo, input int hi);
    int gap;
    int wait_cnt;
    tagged_word_t e;
    for (int i = lo; i < hi; i++) begin
      gap = $urandom % 3;
      repeat (gap) begin
        in_vld <= 1'b0;
        @(posedge clk_net);
      end
      in_vld     <= 1'b1;
      in_sop     <= rows[i].sop;
      in_eop     <= rows[i].eop;
      in_length  <= rows[i].len;
      in_data    <= rows[i].data;
      type_word  <= rows[i].tw;
      type_off   <= rows[i].to;
      wait_cnt = 0;
      forever begin
        @(negedge clk_net);
        if (in_rdy) break;
        wait_cnt++;
        if (wait_cnt > TMO) abort("waiting for in_rdy");
      end
      @(posedge clk_net);
      accepted++;
      // Words outside an open packet are dropped
      if (rows[i].sop || in_pkt) begin
        e.word.sop    = rows[i].sop;
        e.word.eop    = rows[i].eop;
        e.word.length = rows[i].len;
        e.word.data   = rows[i].data;
        e.hit         = rows[i].eop ? rows[i].hit : 1'b0;
        e.buffer      = rows[i].eop ? rows[i].bf : 4'd0;
        expq.push_back(e);
        in_pkt = !rows[i].eop;
      end
      rows_done++;
    end
    in_vld <= 1'b0;
  endtask

  // Output monitor, sampled mid-cycle where everything is settled
  always @(negedge clk_net) begin
    if (!rst) begin
      if (out_vld && stalled_prev) begin
        checks++;
        assert ({out_sop, out_eop, out_length, out_data, out_hit, out_buffer} == held)
          else begin
            $display("MISMATCH out_word held: got %h exp %h",
                     {out_sop, out_eop, out_length, out_data, out_hit, out_buffer}, held);
            errors++;
          end
      end
      stalled_prev = out_vld && !out_rdy;
      held = {out_sop, out_eop, out_length, out_data, out_hit, out_buffer};
      if (out_vld && out_rdy) begin
        checks++;
        assert (expq.size() != 0) else begin
          $display("ERROR: output word %h appeared with nothing expected", out_data);
          errors++;
        end
        if (expq.size() != 0) begin
          assert (out_sop == expq[0].word.sop) else begin
            $display("MISMATCH out_sop: got %h exp %h", out_sop, expq[0].word.sop);
            errors++;
          end
          assert (out_eop == expq[0].word.eop) else begin
            $display("MISMATCH out_eop: got %h exp %h", out_eop, expq[0].word.eop);
            errors++;
          end
          assert (out_length == expq[0].word.length) else begin
            $display("MISMATCH out_length: got %h exp %h", out_length, expq[0].word.length);
            errors++;
          end
          assert (out_data == expq[0].word.data) else begin
            $display("MISMATCH out_data: got %h exp %h", out_data, expq[0].word.data);
            errors++;
          end
          assert (out_hit == expq[0].hit) else begin
            $display("MISMATCH out_hit: got %h exp %h", out_hit, expq[0].hit);
            errors++;
          end
          assert (out_buffer == expq[0].buffer) else begin
            $display("MISMATCH out_buffer: got %h exp %h", out_buffer, expq[0].buffer);
            errors++;
          end
          void'(expq.pop_front());
        end
      end
    end
  end

  initial begin
    // One seed for the whole run
    void'($urandom(32'h5112_ba6b));
    rst = 1'b1;
    in_vld = 1'b0;
    in_sop = 1'b0;
    in_eop = 1'b0;
    in_length = '0;
    in_data = '0;
    type_word = '0;
    type_off = '0;
    type_value = TV;
    out_rdy = 1'b0;
    hold_rdy = 1'b0;
    in_pkt = 1'b0;
    stalled_prev = 1'b0;
    errors = 0;
    checks = 0;
    accepted = 0;
    rows_done = 0;
    // Entries 0 and 1 share word 1 and SA, entry 3 is invalid
    sym_valid  = 4'b0111;
    sym_word   = {4'd1, 4'd2, 4'd1, 4'd1};
    sym_value  = {SC, SB, SA, SA};
    sym_buffer = {4'd12, 4'd9, 4'd6, 4'd5};

    // Every length, type never reached
    for (int i = 0; i < 8; i++) begin
      add_row(i == 0, i == 7, 3'(i), 64'h0101_0101_0101_0101 * 64'(i + 1), 4'd15, 3'd0, 0, 0);
    end
    // Type at offsets 0 to 4, two entries in one word, later word wins, partial word
    add_row(1, 0, 7, 64'(TV), 0, 0, 0, 0);
    add_row(0, 1, 7, SA, 0, 0, 1, 6);
    add_row(1, 0, 7, 64'(TV) << 8, 0, 1, 0, 0);
    add_row(0, 0, 7, SA, 0, 1, 0, 0);
    add_row(0, 1, 7, SB, 0, 1, 1, 9);
    add_row(0, 0, 7, 64'hDEAD_0000_0000_BEEF, 0, 0, 0, 0);
    add_row(1, 0, 7, 64'(TV) << 16, 0, 2, 0, 0);
    add_row(0, 1, 7, SC, 0, 2, 0, 0);
    add_row(1, 0, 7, 64'(TV) << 24, 0, 3, 0, 0);
    add_row(0, 0, 7, SA, 0, 3, 0, 0);
    // Short word with SB would move the buffer to 9 if it matched
    add_row(0, 1, 6, SB, 0, 3, 1, 6);
    add_row(1, 0, 7, 64'(TV) << 32, 0, 4, 0, 0);
    add_row(0, 1, 7, SA, 0, 4, 1, 6);
    // Offset 5, type past length, type in the wrong word
    add_row(1, 0, 7, (64'(TV) << 40) | 64'(TV >> 24), 0, 5, 0, 0);
    add_row(0, 1, 7, SA, 0, 5, 0, 0);
    add_row(0, 1, 7, 64'h0BAD_0BAD_0BAD_0BAD, 0, 0, 0, 0);
    add_row(1, 0, 6, 64'(TV) << 32, 0, 4, 0, 0);
    add_row(0, 1, 7, SA, 0, 4, 0, 0);
    add_row(1, 0, 7, 64'(TV), 1, 0, 0, 0);
    add_row(0, 1, 7, SA, 1, 0, 0, 0);
    // Restart mid-packet with settings that no longer find the type
    add_row(1, 0, 7, 64'(TV), 0, 0, 0, 0);
    add_row(0, 0, 7, SA, 0, 0, 0, 0);
    add_row(1, 0, 7, 64'(TV), 3, 0, 0, 0);
    add_row(0, 1, 7, SA, 3, 0, 0, 0);
    // Burst for the back-pressure phase
    for (int i = 0; i < 12; i++) begin
      add_row(i == 0, i == 11, 7, 64'hB000 + 64'(i), 4'd15, 3'd0, 0, 0);
    end

    repeat (3) @(posedge clk_net);
    rst <= 1'b0;
    @(negedge clk_net);
    checks++;
    assert (!out_vld)
      else begin
        $display("MISMATCH out_vld: got %h exp %h", out_vld, 1'b0);
        errors++;
      end
    checks++;
    assert (in_rdy)
      else begin
        $display("MISMATCH in_rdy: got %h exp %h", in_rdy, 1'b1);
        errors++;
      end
    @(posedge clk_net);
    send_rows(0, rows.size() - 12);

    // Let the pipeline empty so only burst words hold credits
    guard = 0;
    do begin
      @(negedge clk_net);
      guard++;
      if (guard > TMO) abort("draining before the stall phase");
    end while (expq.size() != 0);

    // Hold the output and fill every credit
    hold_rdy = 1'b1;
    @(posedge clk_net);
    acc_before = accepted;
    fork
      send_rows(rows.size() - 12, rows.size());
    join_none
    guard = 0;
    do begin
      @(negedge clk_net);
      guard++;
      if (guard > TMO) abort("waiting for in_rdy to fall");
    end while (in_rdy);
    // FIFO credits plus the first word parked in the output register
    checks++;
    assert (accepted - acc_before == `PM_FIFO_DEPTH + 1)
      else begin
        $display("MISMATCH words accepted before in_rdy fell: got %h exp %h",
                 accepted - acc_before, `PM_FIFO_DEPTH + 1);
        errors++;
      end
    repeat (10) @(negedge clk_net);
    hold_rdy = 1'b0;
    guard = 0;
    while (rows_done < rows.size() || expq.size() != 0) begin
      @(posedge clk_net);
      guard++;
      if (guard > TMO * 4) abort("draining the output");
    end
    repeat (5) @(posedge clk_net);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- pkt_match.f
+incdir+rtl
rtl/pkt_match_pkg.sv
rtl/pkt_stream_ifs.sv
rtl/word_matcher.sv
rtl/tag_fifo.sv
rtl/egress_stage.sv
rtl/pkt_match_top.sv
verification/pkt_match_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = pkt_match_tb
FILELIST  = pkt_match.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
